/* logic/mulPkg.sv */
package mulPkg;

	// operand and product sizes of the default array
	localparam int OperandWidth = 32;
	localparam int ProductWidth = 2 * OperandWidth;

	// adder rows between two pipeline registers
	localparam int DefaultRowsPerStage = 8;

	typedef logic [OperandWidth-1:0] operandT;

	// a is the multiplicand, b the multiplier
	typedef struct packed {
		logic valid;
		operandT a;
		operandT b;
	} mulReqT;

	typedef struct packed {
		operandT hi;
		operandT lo;
	} productHalvesT;

	// full word for the array, two halves for the register map
	typedef union packed {
		logic [ProductWidth-1:0] full;
		productHalvesT half;
	} productT;

	typedef struct packed {
		logic valid;
		productT product;
	} mulRspT;

endpackage

/* logic/apbPkg.sv */
package apbPkg;

	localparam int AddrWidth = 8;
	localparam int DataWidth = 32;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [AddrWidth-1:0] paddr;
		logic [DataWidth-1:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic [DataWidth-1:0] prdata;
		logic pready;
		logic pslverr;
	} apbRspT;

	// register map
	localparam logic [AddrWidth-1:0] AddrOpA = 8'h00;
	localparam logic [AddrWidth-1:0] AddrOpB = 8'h04;
	localparam logic [AddrWidth-1:0] AddrCtrl = 8'h08;
	localparam logic [AddrWidth-1:0] AddrStatus = 8'h0C;
	localparam logic [AddrWidth-1:0] AddrResLo = 8'h10;
	localparam logic [AddrWidth-1:0] AddrResHi = 8'h14;

	// bit positions inside ctrl and status
	localparam int CtrlStartBit = 0;
	localparam int StatusBusyBit = 0;
	localparam int StatusDoneBit = 1;

endpackage

/* logic/prefixAdder.sv */
`timescale 1ns/1ps

module prefixAdder #(
	parameter int Width = mulPkg::OperandWidth
) (
	input logic [Width-1:0] a,
	input logic [Width-1:0] b,
	output logic [Width-1:0] sum,
	output logic cout
);

	localparam int Levels = $clog2(Width);

	logic [Width-1:0] genBits;
	logic [Width-1:0] propBits;

	// bitwise generate and propagate
	assign genBits = a & b;
	assign propBits = a ^ b;

	// Kogge-Stone tree where the span doubles per level
	for (genvar lvl = 0; lvl < Levels; lvl++) begin : genLevel
		localparam int Span = 1 << lvl;

		logic [Width-1:0] gIn;
		logic [Width-1:0] pIn;
		logic [Width-1:0] gOut;

		if (lvl == 0) begin : genLeaf
			assign gIn = genBits;
			assign pIn = propBits;
		end else begin : genNode
			// group propagate of the previous level widened by its span
			assign pIn = genLevel[lvl-1].pIn & (genLevel[lvl-1].pIn << (Span / 2));
			assign gIn = genLevel[lvl-1].gOut;
		end

		// bits below Span already reach bit 0 and pass through
		assign gOut = gIn | (pIn & (gIn << Span));
	end

	// carry into bit i is the group generate of bits i-1 down to 0
	assign sum = propBits ^ {genLevel[Levels-1].gOut[Width-2:0], 1'b0};
	assign cout = genLevel[Levels-1].gOut[Width-1];

endmodule

/* logic/mulRow.sv */
`timescale 1ns/1ps

module mulRow #(
	parameter int Width = mulPkg::OperandWidth
) (
	input logic [Width-1:0] acc,
	input logic accCarry,
	input logic [Width-1:0] a,
	input logic bBit,
	output logic [Width-1:0] sum,
	output logic cout,
	output logic productBit
);

	logic [Width-1:0] partial;
	logic [Width-1:0] shifted;

	// one row of partial products
	assign partial = a & {Width{bBit}};

	// previous sum moves down one place and its carry becomes the top bit
	assign shifted = {accCarry, acc[Width-1:1]};

	// the bit shifted out is final
	assign productBit = acc[0];

	prefixAdder #(
		.Width(Width)
	) prefixAdder_i (
		.a(shifted),
		.b(partial),
		.sum(sum),
		.cout(cout)
	);

endmodule

/* logic/mulArray.sv */
`timescale 1ns/1ps

module mulArray #(
	parameter int Width = mulPkg::OperandWidth,
	parameter int RowsPerStage = mulPkg::DefaultRowsPerStage
) (
	input logic clk,
	input logic arstN,
	input mulPkg::mulReqT req,
	output mulPkg::mulRspT rsp
);
	import mulPkg::*;

	logic inValid;
	logic [Width-1:0] inA;
	logic [Width-1:0] inB;
	logic outValid;
	logic [2*Width-1:0] outProduct;

	// operand register in front of the rows
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			inValid <= 1'b0;
		end else begin
			inValid <= req.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (req.valid) begin
			inA <= req.a[Width-1:0];
			inB <= req.b[Width-1:0];
		end
	end

	for (genvar k = 0; k < Width; k++) begin : genRow
		// row results
		logic [Width-1:0] sumD;
		logic carryD;
		logic [Width-2:0] lowD;
		logic validD;
		// operands for this row with b shifted so its active bit sits at 0
		logic [Width-1:0] aQ;
		logic [Width-1:0] bQ;

		if (k == 0) begin : genFirst
			assign aQ = inA;
			assign bQ = inB;
			assign sumD = aQ & {Width{bQ[0]}};
			assign carryD = 1'b0;
			assign lowD = '0;
			assign validD = inValid;
		end else begin : genChain
			logic [Width-1:0] sumQ;
			logic carryQ;
			logic [Width-2:0] lowQ;
			logic productBit;

			if (k > 1 && (k - 1) % RowsPerStage == 0) begin : genStageReg
				always_ff @(posedge clk or negedge arstN) begin
					if (!arstN) begin
						validD <= 1'b0;
					end else begin
						validD <= genRow[k-1].validD;
					end
				end

				always_ff @(posedge clk) begin
					if (genRow[k-1].validD) begin
						sumQ <= genRow[k-1].sumD;
						carryQ <= genRow[k-1].carryD;
						lowQ <= genRow[k-1].lowD;
						aQ <= genRow[k-1].aQ;
						bQ <= genRow[k-1].bQ >> 1;
					end
				end
			end else begin : genStageWire
				assign validD = genRow[k-1].validD;
				assign sumQ = genRow[k-1].sumD;
				assign carryQ = genRow[k-1].carryD;
				assign lowQ = genRow[k-1].lowD;
				assign aQ = genRow[k-1].aQ;
				assign bQ = genRow[k-1].bQ >> 1;
			end

			mulRow #(
				.Width(Width)
			) mulRow_i (
				.acc(sumQ),
				.accCarry(carryQ),
				.a(aQ),
				.bBit(bQ[0]),
				.sum(sumD),
				.cout(carryD),
				.productBit(productBit)
			);

			// retired bits enter at the top and walk down to their place
			assign lowD = {productBit, lowQ[Width-2:1]};
		end
	end

	// last boundary holds the assembled product
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= genRow[Width-1].validD;
		end
	end

	always_ff @(posedge clk) begin
		if (genRow[Width-1].validD) begin
			outProduct <= {genRow[Width-1].carryD, genRow[Width-1].sumD, genRow[Width-1].lowD};
		end
	end

	always_comb begin
		rsp.valid = outValid;
		rsp.product.full = ProductWidth'(outProduct);
	end

endmodule

/* logic/mulApbRegs.sv */
`timescale 1ns/1ps

module mulApbRegs (
	input logic clk,
	input logic arstN,
	input apbPkg::apbReqT apbReq,
	output apbPkg::apbRspT apbRsp,
	output mulPkg::mulReqT mulReq,
	input mulPkg::mulRspT mulRsp
);
	import apbPkg::*;
	import mulPkg::*;

	operandT opA;
	operandT opB;
	productT result;
	logic busy;
	logic done;

	logic access;
	logic wrAccess;
	logic rdAccess;
	logic mapped;
	logic startReq;
	logic startOk;
	logic [DataWidth-1:0] readWord;

	// no wait states so everything happens in the access cycle
	assign access = apbReq.psel & apbReq.penable;
	assign wrAccess = access & apbReq.pwrite;
	assign rdAccess = access & ~apbReq.pwrite;

	assign startReq = wrAccess && (apbReq.paddr == AddrCtrl) && apbReq.pwdata[CtrlStartBit];
	// refused while a product is in flight
	assign startOk = startReq & ~busy;

	// address decode and read mux
	always_comb begin
		mapped = 1'b1;
		readWord = '0;
		case (apbReq.paddr)
			AddrOpA: begin
				readWord = opA;
			end
			AddrOpB: begin
				readWord = opB;
			end
			AddrCtrl: begin
				// start is a pulse, reads back as zero
				readWord = '0;
			end
			AddrStatus: begin
				readWord[StatusBusyBit] = busy;
				readWord[StatusDoneBit] = done;
			end
			AddrResLo: begin
				readWord = result.half.lo;
			end
			AddrResHi: begin
				readWord = result.half.hi;
			end
			default: begin
				mapped = 1'b0;
			end
		endcase
	end

	always_comb begin
		apbRsp.prdata = rdAccess ? readWord : '0;
		apbRsp.pready = 1'b1;
		apbRsp.pslverr = access & (~mapped | (startReq & busy));
	end

	// operand registers
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			opA <= '0;
			opB <= '0;
		end else if (wrAccess) begin
			if (apbReq.paddr == AddrOpA) begin
				opA <= apbReq.pwdata;
			end
			if (apbReq.paddr == AddrOpB) begin
				opB <= apbReq.pwdata;
			end
		end
	end

	// a response only arrives while busy, so it never meets a start
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (startOk) begin
			busy <= 1'b1;
			done <= 1'b0;
		end else if (mulRsp.valid) begin
			busy <= 1'b0;
			done <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result <= '0;
		end else if (mulRsp.valid) begin
			result <= mulRsp.product;
		end
	end

	// operands go out together with the start pulse
	always_comb begin
		mulReq.valid = startOk;
		mulReq.a = opA;
		mulReq.b = opB;
	end

endmodule

/* logic/mulApbTop.sv */
`timescale 1ns/1ps

module mulApbTop (
	input logic clk,
	input logic arstN,
	input apbPkg::apbReqT apbReq,
	output apbPkg::apbRspT apbRsp
);
	import mulPkg::*;

	mulReqT mulReq;
	mulRspT mulRsp;

	mulApbRegs mulApbRegs_i (
		.clk(clk),
		.arstN(arstN),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.mulReq(mulReq),
		.mulRsp(mulRsp)
	);

	// 32 bit array with a register after every eight rows
	mulArray #(
		.Width(OperandWidth),
		.RowsPerStage(DefaultRowsPerStage)
	) mulArray_i (
		.clk(clk),
		.arstN(arstN),
		.req(mulReq),
		.rsp(mulRsp)
	);

endmodule

/* testbench/mulTbTop.sv */
`timescale 1ns/1ps

module mulTbTop;
	import mulPkg::*;
	import apbPkg::*;

	localparam int HalfPeriod = 4;
	localparam int Stages = (OperandWidth + DefaultRowsPerStage - 2) / DefaultRowsPerStage + 1;
	localparam int RandomCount = 200;
	localparam int CornerCount = 12;
	// reset, busy, unmapped and timing tests count as extra operations
	localparam int OpCount = RandomCount + CornerCount + 8;
	localparam int CycleLimit = OpCount * (Stages + 12) + 200;
	localparam int PollLimit = 4 * Stages;
	localparam logic [15:0] LfsrSeed = 16'd53380;
	localparam logic [15:0] LfsrTaps = 16'hB400;

	localparam operandT CornerA [CornerCount] = '{
		32'h0000_0000, 32'h0000_0000, 32'h0000_0001, 32'h0000_0001,
		32'hFFFF_FFFF, 32'h8000_0000, 32'h0001_0000, 32'h8000_0000,
		32'hAAAA_AAAA, 32'h5555_5555, 32'hAAAA_AAAA, 32'hFFFF_FFFF
	};
	localparam operandT CornerB [CornerCount] = '{
		32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFF,
		32'hFFFF_FFFF, 32'h8000_0000, 32'h0000_8000, 32'h0000_0002,
		32'h5555_5555, 32'h5555_5555, 32'hAAAA_AAAA, 32'h0000_0001
	};

	typedef struct packed {
		productT expected;
		productT seen;
	} productPairT;

	typedef struct packed {
		logic [DataWidth-1:0] expected;
		logic [DataWidth-1:0] seen;
	} wordPairT;

	typedef struct packed {
		logic expected;
		logic seen;
	} errPairT;

	logic clk;
	logic arstN;
	apbReqT apbReq;
	apbRspT apbRsp;

	int cycleCount = 0;
	int mismatchCount = 0;
	int failCount = 0;
	int accessCycle;
	logic [15:0] lfsrState;
	productT lastProduct;

	// results waiting for the comparing process
	productPairT productQ[$];
	string productNameQ[$];
	wordPairT wordQ[$];
	string wordNameQ[$];
	errPairT errQ[$];
	string errNameQ[$];

	mulApbTop mulApbTop_i (
		.clk(clk),
		.arstN(arstN),
		.apbReq(apbReq),
		.apbRsp(apbRsp)
	);

	initial begin
		clk = 1'b0;
		forever #HalfPeriod clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// one shift with taps folded in when a one drops out
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ LfsrTaps;
		end
		return state >> 1;
	endfunction

	task automatic drawOperand(output operandT word);
		word = '0;
		for (int i = 0; i < OperandWidth; i++) begin
			lfsrState = lfsrStep(lfsrState);
			word = {word[OperandWidth-2:0], lfsrState[0]};
		end
	endtask

	function automatic productT refProduct(input operandT a, input operandT b);
		productT p;
		p.full = {{OperandWidth{1'b0}}, a} * {{OperandWidth{1'b0}}, b};
		return p;
	endfunction

	task automatic checkProduct(input string name, input productT expected, input productT seen);
		if (seen !== expected) begin
			$display("mismatch at %0t: %s expected %h seen %h", $time, name, expected, seen);
			mismatchCount++;
		end
	endtask

	task automatic checkWord(input string name, input logic [DataWidth-1:0] expected,
		input logic [DataWidth-1:0] seen);
		if (seen !== expected) begin
			$display("mismatch at %0t: %s expected %h seen %h", $time, name, expected, seen);
			mismatchCount++;
		end
	endtask

	task automatic checkErr(input string name, input logic expected, input logic seen);
		if (seen !== expected) begin
			$display("mismatch at %0t: %s expected %b seen %b", $time, name, expected, seen);
			mismatchCount++;
		end
	endtask

	// comparing process
	always @(negedge clk) begin
		productPairT pp;
		wordPairT wp;
		errPairT ep;
		string name;
		while (productQ.size() > 0) begin
			pp = productQ.pop_front();
			name = productNameQ.pop_front();
			checkProduct(name, pp.expected, pp.seen);
		end
		while (wordQ.size() > 0) begin
			wp = wordQ.pop_front();
			name = wordNameQ.pop_front();
			checkWord(name, wp.expected, wp.seen);
		end
		while (errQ.size() > 0) begin
			ep = errQ.pop_front();
			name = errNameQ.pop_front();
			checkErr(name, ep.expected, ep.seen);
		end
	end

	task automatic pushWord(input string name, input logic [DataWidth-1:0] expected,
		input logic [DataWidth-1:0] seen);
		wordQ.push_back('{expected: expected, seen: seen});
		wordNameQ.push_back(name);
	endtask

	task automatic pushErr(input string name, input logic expected, input logic seen);
		errQ.push_back('{expected: expected, seen: seen});
		errNameQ.push_back(name);
	endtask

	// called on a falling edge and returns on the falling edge after the access
	task automatic apbWrite(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
		output logic err);
		apbReq.psel = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite = 1'b1;
		apbReq.paddr = addr;
		apbReq.pwdata = data;
		@(negedge clk);
		apbReq.penable = 1'b1;
		// sample just ahead of the rising edge that ends the access
		#(HalfPeriod - 1);
		err = apbRsp.pslverr;
		pushErr("pready", 1'b1, apbRsp.pready);
		accessCycle = cycleCount;
		@(negedge clk);
		apbReq.psel = 1'b0;
		apbReq.penable = 1'b0;
	endtask

	task automatic apbRead(input logic [AddrWidth-1:0] addr, output logic [DataWidth-1:0] data,
		output logic err);
		apbReq.psel = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite = 1'b0;
		apbReq.paddr = addr;
		apbReq.pwdata = '0;
		@(negedge clk);
		apbReq.penable = 1'b1;
		#(HalfPeriod - 1);
		data = apbRsp.prdata;
		err = apbRsp.pslverr;
		pushErr("pready", 1'b1, apbRsp.pready);
		accessCycle = cycleCount;
		@(negedge clk);
		apbReq.psel = 1'b0;
		apbReq.penable = 1'b0;
	endtask

	task automatic writeReg(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
		input logic expErr, input string name);
		logic err;
		apbWrite(addr, data, err);
		pushErr(name, expErr, err);
	endtask

	task automatic readReg(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] expData,
		input logic expErr, input string name);
		logic [DataWidth-1:0] data;
		logic err;
		apbRead(addr, data, err);
		pushWord(name, expData, data);
		pushErr({name, " pslverr"}, expErr, err);
	endtask

	task automatic waitDone();
		logic [DataWidth-1:0] data;
		logic err;
		logic seenDone;
		int polls;
		seenDone = 1'b0;
		polls = 0;
		while (!seenDone && polls < PollLimit) begin
			apbRead(AddrStatus, data, err);
			pushErr("status pslverr", 1'b0, err);
			seenDone = data[StatusDoneBit];
			polls++;
		end
		if (!seenDone) begin
			$display("status never reported done within %0d polls", PollLimit);
			failCount++;
		end
	endtask

	task automatic startProduct(input operandT a, input operandT b);
		writeReg(AddrOpA, a, 1'b0, "opA write pslverr");
		writeReg(AddrOpB, b, 1'b0, "opB write pslverr");
		writeReg(AddrCtrl, 32'h1, 1'b0, "start pslverr");
	endtask

	task automatic finishProduct(input operandT a, input operandT b);
		logic [DataWidth-1:0] lo;
		logic [DataWidth-1:0] hi;
		logic err;
		productT seen;
		waitDone();
		apbRead(AddrResLo, lo, err);
		pushErr("result lo pslverr", 1'b0, err);
		apbRead(AddrResHi, hi, err);
		pushErr("result hi pslverr", 1'b0, err);
		seen.half.lo = lo;
		seen.half.hi = hi;
		lastProduct = refProduct(a, b);
		productQ.push_back('{expected: lastProduct, seen: seen});
		productNameQ.push_back("product");
	endtask

	task automatic checkUnmapped(input logic [AddrWidth-1:0] addr);
		writeReg(addr, 32'hFFFF_FFFF, 1'b1, "unmapped write pslverr");
		readReg(addr, 32'h0, 1'b1, "unmapped prdata");
	endtask

	task automatic checkStatusTiming(input operandT a, input operandT b);
		logic [DataWidth-1:0] data;
		logic [DataWidth-1:0] expected;
		logic err;
		int startCycle;
		startProduct(a, b);
		startCycle = accessCycle;
		// busy until Stages + 1 cycles after the start access
		do begin
			apbRead(AddrStatus, data, err);
			expected = (accessCycle - startCycle >= Stages + 1) ? 32'h2 : 32'h1;
			pushWord("status timing", expected, data);
			pushErr("status pslverr", 1'b0, err);
		end while (expected != 32'h2);
		finishProduct(a, b);
	endtask

	initial begin
		operandT a;
		operandT b;
		apbReq = '0;
		arstN = 1'b0;
		lfsrState = LfsrSeed;
		repeat (2) @(negedge clk);
		arstN = 1'b1;

		readReg(AddrStatus, 32'h0, 1'b0, "status after reset");
		readReg(AddrResLo, 32'h0, 1'b0, "result lo after reset");
		readReg(AddrResHi, 32'h0, 1'b0, "result hi after reset");

		for (int i = 0; i < RandomCount; i++) begin
			drawOperand(a);
			drawOperand(b);
			startProduct(a, b);
			finishProduct(a, b);
		end

		for (int i = 0; i < CornerCount; i++) begin
			startProduct(CornerA[i], CornerB[i]);
			finishProduct(CornerA[i], CornerB[i]);
		end

		// a new operand while busy must not reach the array through a refused start
		startProduct(32'hDEAD_BEEF, 32'h0BAD_F00D);
		writeReg(AddrOpA, 32'h7654_3210, 1'b0, "opA write while busy pslverr");
		writeReg(AddrCtrl, 32'h1, 1'b1, "start while busy pslverr");
		finishProduct(32'hDEAD_BEEF, 32'h0BAD_F00D);

		writeReg(AddrOpA, 32'h1234_5678, 1'b0, "opA write pslverr");
		writeReg(AddrOpB, 32'h9ABC_DEF0, 1'b0, "opB write pslverr");
		checkUnmapped(8'h18);
		checkUnmapped(8'h02);
		checkUnmapped(8'h40);
		checkUnmapped(8'hFC);
		writeReg(AddrStatus, 32'hFFFF_FFFF, 1'b0, "status write pslverr");
		writeReg(AddrResLo, 32'hFFFF_FFFF, 1'b0, "result lo write pslverr");
		writeReg(AddrResHi, 32'hFFFF_FFFF, 1'b0, "result hi write pslverr");
		readReg(AddrOpA, 32'h1234_5678, 1'b0, "opA readback");
		readReg(AddrOpB, 32'h9ABC_DEF0, 1'b0, "opB readback");
		readReg(AddrStatus, 32'h2, 1'b0, "status readback");
		readReg(AddrResLo, lastProduct.half.lo, 1'b0, "result lo readback");
		readReg(AddrResHi, lastProduct.half.hi, 1'b0, "result hi readback");

		checkStatusTiming(32'h0F0F_1234, 32'hC3C3_0081);

		wait (productQ.size() == 0 && wordQ.size() == 0 && errQ.size() == 0);
		@(negedge clk);
		$display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* mulArray.f */
logic/mulPkg.sv
logic/apbPkg.sv
logic/prefixAdder.sv
logic/mulRow.sv
logic/mulArray.sv
logic/mulApbRegs.sv
logic/mulApbTop.sv
testbench/mulTbTop.sv

/* build.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing -j 0 --top-module mulTbTop \
	-f mulArray.f --Mdir build/obj -o mulTbSim

./build/obj/mulTbSim | tee build/sim.log

if grep -qx "TEST OK" build/sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see build/sim.log"
	exit 1
fi
